// File: sim.f
common/boardPkg.sv
design/videoTiming.sv
design/busDecode.sv
charLayer/charLayer.sv
palette/palette.sv
design/boardA.sv
verification/boardATb.sv

// File: verification/boardATb.sv
`timescale 1ns/1ns

module boardATb;

	import boardPkg::*;

	localparam int HALF_PERIOD   = 50;
	localparam int BUS_TIMEOUT   = 200;
	localparam int FRAME_TIMEOUT = 3000;

	logic       G6M;
	logic       reset;
	apbReqT     apbReq;
	apbRspT     apbRsp;
	playerT     player1;
	playerT     player2;
	logic [7:0] dipA;
	logic [7:0] dipB;
	rasterT     raster;
	videoT      video;
	logic       irq;

	// Host-side copies of everything written
	logic [7:0] charShadow [16];
	logic [7:0] fontShadow [256];
	logic [7:0] palShadow [128];
	logic       shadowFlip;

	int     checkCount;
	int     errorCount;
	int     timeoutCount;
	int     visibleChecked;
	int     histCount;
	bit     monitorOn;
	bit     checkEnable;
	string  frameName;
	rasterT hist [2];

	boardA boardA_i (
		.G6M    (G6M),
		.reset  (reset),
		.apbReq (apbReq),
		.apbRsp (apbRsp),
		.player1(player1),
		.player2(player2),
		.dipA   (dipA),
		.dipB   (dipB),
		.raster (raster),
		.video  (video),
		.irq    (irq)
	);

	initial begin
		G6M = 1'b0;
		forever #HALF_PERIOD G6M = ~G6M;
	end

	task automatic endRun();
		$display("Checks: %0d  mismatches: %0d  timeouts: %0d", checkCount, errorCount,
			timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checkCount++;
		if (expected !== actual) begin
			errorCount++;
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	function automatic videoT pixelRef(input int h, input int v, input bit flipOn);
		int         sx;
		int         sy;
		int         tile;
		int         fontOfs;
		int         idx;
		logic [3:0] code;
		logic [3:0] colour;
		logic       p0;
		logic       p1;
		videoT      result;
		result = '0;
		result.blank = 1'b1;
		if (h >= H_VISIBLE || v >= V_VISIBLE)
			return result;
		sx = flipOn ? (H_VISIBLE - 1 - h) : h;
		sy = flipOn ? (V_VISIBLE - 1 - v) : v;
		tile = (sy / 8) * TILE_COLS + sx / 8;
		code = charShadow[tile][3:0];
		colour = charShadow[tile][7:4];
		fontOfs = (int'(code) * 8 + sy % 8) * 2;
		p0 = fontShadow[fontOfs][7 - sx % 8];
		p1 = fontShadow[fontOfs + 1][7 - sx % 8];
		idx = int'(colour) * 4 + int'(p1) * 2 + int'(p0);
		result.rgb.r = palShadow[idx * 2][7:4];
		result.rgb.g = palShadow[idx * 2][3:0];
		result.rgb.b = palShadow[idx * 2 + 1][3:0];
		result.blank = 1'b0;
		return result;
	endfunction

	task automatic apbAccess(input bit isWrite, input logic [11:0] addr,
			input logic [7:0] wdata, output logic [7:0] rdata, output rasterT doneRaster);
		int waits;
		bit ready;
		waits = 0;
		ready = 1'b0;
		rdata = 'x;
		doneRaster = '0;
		@(negedge G6M);
		apbReq.psel = 1'b1;	// Setup phase
		apbReq.penable = 1'b0;
		apbReq.pwrite = isWrite;
		apbReq.paddr = addr;
		apbReq.pwdata = wdata;
		@(negedge G6M);
		apbReq.penable = 1'b1;
		while (!ready) begin
			#(HALF_PERIOD / 2);	// Mid low phase, outputs settled
			if (apbRsp.pready) begin
				ready = 1'b1;
				rdata = apbRsp.prdata;
				doneRaster = raster;
			end else if (waits >= BUS_TIMEOUT) begin
				timeoutCount++;
				$display("Timeout: APB access to address %h never completed", addr);
				endRun();
			end else begin
				waits++;
				@(negedge G6M);
			end
		end
		@(negedge G6M);	// Transfer done on the edge in between
		apbReq.psel = 1'b0;
		apbReq.penable = 1'b0;
	endtask

	task automatic writeMem(input logic [11:0] addr, input logic [7:0] data);
		logic [7:0] unused;
		rasterT     at;
		apbAccess(1'b1, addr, data, unused, at);
		if (addr < 12'h010)
			charShadow[addr[3:0]] = data;
		else if (addr[11:8] == 4'h1)
			fontShadow[addr[7:0]] = data;
		else if (addr >= 12'h200 && addr < 12'h280)
			palShadow[addr[6:0]] = data;
		else if (addr == 12'h380)
			shadowFlip = data[0];
	endtask

	task automatic readCheck(input string name, input logic [11:0] addr,
			input logic [7:0] expected);
		logic [7:0] value;
		rasterT     at;
		apbAccess(1'b0, addr, 8'h00, value, at);
		checkValue(name, expected, value);
	endtask

	task automatic waitRaster(input int h, input int v);
		int cycles;
		bit found;
		cycles = 0;
		found = 1'b0;
		while (!found) begin
			@(negedge G6M);
			if (int'(raster.hCount) == h && int'(raster.vCount) == v) begin
				found = 1'b1;
			end else if (cycles >= FRAME_TIMEOUT) begin
				timeoutCount++;
				$display("Timeout: raster never reached h %0d v %0d", h, v);
				endRun();
			end else begin
				cycles++;
			end
		end
	endtask

	// One full frame against the model, starting at the frame origin
	task automatic checkFrame(input string name);
		waitRaster(0, 0);
		@(posedge G6M);
		frameName = name;
		visibleChecked = 0;
		checkEnable = 1'b1;
		waitRaster(0, 0);
		@(posedge G6M);
		checkEnable = 1'b0;
		checkValue({name, " pixel count"}, 32'(H_VISIBLE * V_VISIBLE), visibleChecked);
	endtask

	// Video compare, two cycles behind the raster
	initial begin
		histCount = 0;
		forever begin
			@(negedge G6M);
			if (!monitorOn) begin
				histCount = 0;
			end else begin
				checkValue("raster blank flags",
					{raster.hCount >= 6'(H_VISIBLE), raster.vCount >= 6'(V_VISIBLE)},
					{raster.hBlank, raster.vBlank});
				if (histCount >= 2) begin
					if (hist[1].hBlank || hist[1].vBlank) begin
						checkValue("blanking", 32'h1, 32'(video));
					end else if (checkEnable) begin
						checkValue(frameName, pixelRef(hist[1].hCount, hist[1].vCount,
							shadowFlip), video);
						visibleChecked++;
					end
				end
				hist[1] = hist[0];
				hist[0] = raster;
				if (histCount < 2)
					histCount++;
			end
		end
	end

	initial begin
		logic [7:0]  data;
		logic [7:0]  rd;
		logic [11:0] addr;
		logic [11:0] unmapped [5];
		rasterT      at;
		void'($urandom(32'hb996));
		reset = 1'b1;
		apbReq = '0;
		player1 = '1;	// Nothing pressed
		player2 = '1;
		dipA = 8'h00;
		dipB = 8'h00;
		shadowFlip = 1'b0;
		checkEnable = 1'b0;
		monitorOn = 1'b0;
		repeat (3) @(negedge G6M);
		checkValue("reset irq", 0, irq);
		checkValue("reset video", 32'h1, 32'(video));
		reset = 1'b0;
		@(posedge G6M);
		monitorOn = 1'b1;

		for (int i = 0; i < 16; i++) begin
			addr = FONT_BASE + 12'($urandom % 256);
			data = 8'($urandom);
			writeMem(addr, data);
			readCheck("font readback", addr, data);
			addr = PAL_BASE + 12'($urandom % 128);
			data = 8'($urandom);
			writeMem(addr, data);
			readCheck("palette readback", addr, data);
		end
		data = 8'($urandom);
		writeMem(CTRL_BASE, data);
		readCheck("control readback", CTRL_BASE, {7'd0, data[0]});
		player1 = playerT'($urandom);
		player2 = playerT'($urandom);
		dipA = 8'($urandom);
		dipB = 8'($urandom);
		repeat (2) @(negedge G6M);	// Input synchronisers
		readCheck("player 1", INPUT_BASE, player1);
		readCheck("player 2", INPUT_BASE + 12'd1, player2);
		readCheck("DIP A", INPUT_BASE + 12'd2, dipA);
		readCheck("DIP B", INPUT_BASE + 12'd3, dipB);
		unmapped = '{12'h010, 12'h280, 12'h304, 12'h382, 12'hfff};
		foreach (unmapped[i])
			readCheck("unmapped read", unmapped[i], 8'hff);

		// Contention, issued early in a visible line
		waitRaster(2, 5);
		addr = CHAR_BASE + 12'($urandom % 16);
		data = 8'($urandom);
		apbAccess(1'b1, addr, data, rd, at);
		charShadow[addr[3:0]] = data;
		checkValue("char write in blank", 1, at.hBlank | at.vBlank);
		checkValue("char write position", {6'd32, 6'd5}, {at.hCount, at.vCount});
		readCheck("char readback", addr, data);

		for (int i = 0; i < 256; i++)
			writeMem(FONT_BASE + 12'(i), 8'($urandom));
		for (int i = 0; i < 128; i++)
			writeMem(PAL_BASE + 12'(i), 8'($urandom));
		for (int i = 0; i < 16; i++)
			writeMem(CHAR_BASE + 12'(i), 8'($urandom));
		writeMem(CTRL_BASE, 8'h00);
		checkFrame("unflipped frame");
		writeMem(CTRL_BASE, 8'h01);
		checkFrame("flipped frame");

		waitRaster(0, V_VISIBLE + 1);
		writeMem(CTRL_BASE + 12'd1, 8'($urandom));
		checkValue("irq cleared", 0, irq);
		readCheck("status clear", CTRL_BASE + 12'd1, 8'h00);
		waitRaster(0, V_VISIBLE);
		checkValue("irq before rise", 0, irq);
		@(negedge G6M);
		checkValue("irq rise", 1, irq);
		readCheck("status pending", CTRL_BASE + 12'd1, 8'h01);
		writeMem(CTRL_BASE + 12'd1, 8'h00);
		checkValue("irq fall", 0, irq);
		waitRaster(0, V_VISIBLE);
		checkValue("irq before next rise", 0, irq);
		@(negedge G6M);
		checkValue("irq next frame", 1, irq);

		endRun();
	end

endmodule

// File: design/boardA.sv
`timescale 1ns/1ns

module boardA (
	input  logic             G6M,
	input  logic             reset,
	input  boardPkg::apbReqT apbReq,
	output boardPkg::apbRspT apbRsp,
	input  boardPkg::playerT player1,
	input  boardPkg::playerT player2,
	input  logic [7:0]       dipA,
	input  logic [7:0]       dipB,
	output boardPkg::rasterT raster,
	output boardPkg::videoT  video,
	output logic             irq
);

	import boardPkg::*;

	cpuBusT     cpuBus;
	palIdxT     pixel;
	logic       charSel;
	logic       fontSel;
	logic       palSel;
	logic [7:0] charRdData;
	logic [7:0] palRdData;
	logic       charReady;
	logic       flip;

	videoTiming videoTiming_i (
		.G6M   (G6M),
		.reset (reset),
		.raster(raster)
	);

	busDecode busDecode_i (
		.G6M       (G6M),
		.reset     (reset),
		.apbReq    (apbReq),
		.apbRsp    (apbRsp),
		.raster    (raster),
		.player1   (player1),
		.player2   (player2),
		.dipA      (dipA),
		.dipB      (dipB),
		.cpuBus    (cpuBus),
		.charSel   (charSel),
		.fontSel   (fontSel),
		.palSel    (palSel),
		.charRdData(charRdData),
		.palRdData (palRdData),
		.charReady (charReady),
		.flip      (flip),
		.irq       (irq)
	);

	charLayer charLayer_i (
		.G6M       (G6M),
		.reset     (reset),
		.raster    (raster),
		.flip      (flip),
		.cpuBus    (cpuBus),
		.charSel   (charSel),
		.fontSel   (fontSel),
		.charRdData(charRdData),
		.charReady (charReady),
		.pixel     (pixel)
	);

	palette palette_i (
		.G6M      (G6M),
		.reset    (reset),
		.cpuBus   (cpuBus),
		.palSel   (palSel),
		.palRdData(palRdData),
		.pixel    (pixel),
		.video    (video)
	);

endmodule

// File: palette/palette.sv
`timescale 1ns/1ns

module palette (
	input  logic             G6M,
	input  logic             reset,
	input  boardPkg::cpuBusT cpuBus,
	input  logic             palSel,
	output logic [7:0]       palRdData,
	input  boardPkg::palIdxT pixel,
	output boardPkg::videoT  video
);

	import boardPkg::*;

	logic [7:0] palRam [128];
	logic [7:0] rgByte;
	logic [7:0] bByte;
	rgbT        colour;

	always_ff @(posedge G6M) begin
		if (palSel && cpuBus.write)
			palRam[cpuBus.addr[6:0]] <= cpuBus.data;
	end

	assign palRdData = palRam[cpuBus.addr[6:0]];

	// Two bytes per entry
	assign rgByte   = palRam[{pixel.index, 1'b0}];
	assign bByte    = palRam[{pixel.index, 1'b1}];
	assign colour.r = rgByte[7:4];
	assign colour.g = rgByte[3:0];
	assign colour.b = bByte[3:0];	// High nibble unused

	always_ff @(posedge G6M) begin
		if (reset) begin
			video.rgb   <= '0;
			video.blank <= 1'b1;
		end else begin
			video.blank <= pixel.blank;
			if (pixel.blank)
				video.rgb <= '0;
			else
				video.rgb <= colour;
		end
	end

endmodule

// File: charLayer/charLayer.sv
`timescale 1ns/1ns

module charLayer (
	input  logic             G6M,
	input  logic             reset,
	input  boardPkg::rasterT raster,
	input  logic             flip,
	input  boardPkg::cpuBusT cpuBus,
	input  logic             charSel,
	input  logic             fontSel,
	output logic [7:0]       charRdData,
	output logic             charReady,
	output boardPkg::palIdxT pixel
);

	import boardPkg::*;

	logic [7:0] charRam [16];
	logic [7:0] fontRam [256];

	logic [4:0] sx;
	logic [4:0] sy;
	logic [3:0] tileIdx;
	logic [3:0] code;
	logic [3:0] colour;
	logic [7:0] plane0Byte;
	logic [7:0] plane1Byte;
	logic [2:0] bitSel;
	logic       activeDisplay;

	assign activeDisplay = !raster.hBlank && !raster.vBlank;

	// Memory-ready equivalent: the video fetch owns the RAM while drawing
	assign charReady = !(charSel && activeDisplay);

	always_ff @(posedge G6M) begin
		if (charSel && cpuBus.write)
			charRam[cpuBus.addr[3:0]] <= cpuBus.data;
		if (fontSel && cpuBus.write)
			fontRam[cpuBus.addr] <= cpuBus.data;
	end

	assign charRdData = fontSel ? fontRam[cpuBus.addr] : charRam[cpuBus.addr[3:0]];

	// Screen mirroring
	always_comb begin
		if (flip) begin
			sx = 5'(H_VISIBLE - 1) - raster.hCount[4:0];
			sy = 5'(V_VISIBLE - 1) - raster.vCount[4:0];
		end else begin
			sx = raster.hCount[4:0];
			sy = raster.vCount[4:0];
		end
	end

	assign tileIdx = 4'(int'(sy[4:3]) * TILE_COLS + int'(sx[4:3]));
	assign code    = charRam[tileIdx][3:0];
	assign colour  = charRam[tileIdx][7:4];

	// Font byte offset is {code, row, plane}
	assign plane0Byte = fontRam[{code, sy[2:0], 1'b0}];
	assign plane1Byte = fontRam[{code, sy[2:0], 1'b1}];
	assign bitSel     = 3'd7 - sx[2:0];	// Bit 7 is leftmost

	always_ff @(posedge G6M) begin
		if (reset) begin
			pixel.index <= '0;
			pixel.blank <= 1'b1;
		end else begin
			pixel.index <= {colour, plane1Byte[bitSel], plane0Byte[bitSel]};
			pixel.blank <= raster.hBlank || raster.vBlank;
		end
	end

	assertNoDrawWrite: assert property (
		@(posedge G6M) disable iff (reset)
		(charSel && cpuBus.write) |-> !activeDisplay
	) else $error("Character write during active display");

endmodule

// File: design/busDecode.sv
`timescale 1ns/1ns

module busDecode (
	input  logic             G6M,
	input  logic             reset,
	input  boardPkg::apbReqT apbReq,
	output boardPkg::apbRspT apbRsp,
	input  boardPkg::rasterT raster,
	input  boardPkg::playerT player1,
	input  boardPkg::playerT player2,
	input  logic [7:0]       dipA,
	input  logic [7:0]       dipB,
	output boardPkg::cpuBusT cpuBus,
	output logic             charSel,
	output logic             fontSel,
	output logic             palSel,
	input  logic [7:0]       charRdData,
	input  logic [7:0]       palRdData,
	input  logic             charReady,
	output logic             flip,
	output logic             irq
);

	import boardPkg::*;

	busStateT        state;
	regionT          region;
	logic            accessPhase;
	logic            done;
	logic [3:0][7:0] inMeta;
	logic [3:0][7:0] inSync;
	logic [7:0]      rdData;
	logic            vBlankDly;

	always_comb begin
		if (apbReq.paddr[11:4] == CHAR_BASE[11:4])
			region = REG_CHAR;
		else if (apbReq.paddr[11:8] == FONT_BASE[11:8])
			region = REG_FONT;
		else if (apbReq.paddr[11:7] == PAL_BASE[11:7])
			region = REG_PAL;
		else if (apbReq.paddr[11:2] == INPUT_BASE[11:2])
			region = REG_INPUT;
		else if (apbReq.paddr[11:1] == CTRL_BASE[11:1])
			region = REG_CTRL;
		else
			region = REG_NONE;
	end

	assign accessPhase = (state == BUS_WAIT) && apbReq.psel && apbReq.penable;
	assign done        = accessPhase && ((region != REG_CHAR) || charReady);

	assign charSel = apbReq.psel && (region == REG_CHAR);
	assign fontSel = apbReq.psel && (region == REG_FONT);
	assign palSel  = apbReq.psel && (region == REG_PAL);

	assign cpuBus.write = apbReq.pwrite && done;	// Write strobe on the final edge
	assign cpuBus.addr  = apbReq.paddr[7:0];
	assign cpuBus.data  = apbReq.pwdata;

	always_comb begin
		case (region)
			REG_CHAR, REG_FONT: rdData = charRdData;
			REG_PAL:            rdData = palRdData;
			REG_INPUT:          rdData = inSync[apbReq.paddr[1:0]];
			REG_CTRL:           rdData = {7'd0, apbReq.paddr[0] ? irq : flip};
			default:            rdData = 8'hff;
		endcase
		apbRsp.prdata = rdData;
		apbRsp.pready = done;
	end

	always_ff @(posedge G6M) begin
		if (reset) begin
			state <= BUS_IDLE;
		end else begin
			case (state)
				BUS_IDLE: if (apbReq.psel && !apbReq.penable) state <= BUS_WAIT;
				BUS_WAIT: if (done) state <= BUS_IDLE;
				default:  state <= BUS_IDLE;
			endcase
		end
	end

	// Two-flop synchronisers for the board inputs
	always_ff @(posedge G6M) begin
		inMeta <= {dipB, dipA, player2, player1};
		inSync <= inMeta;
	end

	always_ff @(posedge G6M) begin
		if (reset) begin
			flip      <= 1'b0;
			irq       <= 1'b0;
			vBlankDly <= 1'b0;
		end else begin
			vBlankDly <= raster.vBlank;
			if (done && apbReq.pwrite && (region == REG_CTRL) && !apbReq.paddr[0])
				flip <= apbReq.pwdata[0];
			if (raster.vBlank && !vBlankDly && !raster.hBlank)
				irq <= 1'b1;	// First line of vertical blank
			else if (done && apbReq.pwrite && (region == REG_CTRL) && apbReq.paddr[0])
				irq <= 1'b0;
		end
	end

	assertHoldRequest: assert property (
		@(posedge G6M) disable iff (reset)
		(apbReq.psel && apbReq.penable && !apbRsp.pready) |=> $stable(apbReq)
	) else $error("APB request changed during wait state");

endmodule

// File: design/videoTiming.sv
`timescale 1ns/1ns

module videoTiming (
	input  logic            G6M,
	input  logic            reset,
	output boardPkg::rasterT raster
);

	import boardPkg::*;

	logic [5:0] hNext;
	logic [5:0] vNext;
	logic       lineEnd;

	assign lineEnd = (raster.hCount == 6'(H_TOTAL - 1));

	always_comb begin
		if (lineEnd) begin
			hNext = '0;
			if (raster.vCount == 6'(V_TOTAL - 1))
				vNext = '0;	// Frame wrap
			else
				vNext = raster.vCount + 6'd1;
		end else begin
			hNext = raster.hCount + 6'd1;
			vNext = raster.vCount;
		end
	end

	// Blanking follows the counter value it is registered with
	always_ff @(posedge G6M) begin
		if (reset) begin
			raster <= '0;
		end else begin
			raster.hCount <= hNext;
			raster.vCount <= vNext;
			raster.hBlank <= (hNext >= 6'(H_VISIBLE));
			raster.vBlank <= (vNext >= 6'(V_VISIBLE));
		end
	end

	assertCounterRange: assert property (
		@(posedge G6M) disable iff (reset)
		(int'(raster.hCount) < H_TOTAL) && (int'(raster.vCount) < V_TOTAL)
	) else $error("Raster counter out of range");

endmodule

// File: common/boardPkg.sv
package boardPkg;

	localparam int H_TOTAL   = 64;
	localparam int H_VISIBLE = 32;
	localparam int V_TOTAL   = 40;
	localparam int V_VISIBLE = 32;
	localparam int TILE_COLS = 4;

	localparam logic [11:0] CHAR_BASE  = 12'h000;
	localparam logic [11:0] FONT_BASE  = 12'h100;
	localparam logic [11:0] PAL_BASE   = 12'h200;
	localparam logic [11:0] INPUT_BASE = 12'h300;
	localparam logic [11:0] CTRL_BASE  = 12'h380;

	typedef struct packed {
		logic [5:0] hCount;
		logic [5:0] vCount;
		logic       hBlank;
		logic       vBlank;
	} rasterT;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [11:0] paddr;
		logic [7:0]  pwdata;
	} apbReqT;

	typedef struct packed {
		logic [7:0] prdata;
		logic       pready;
	} apbRspT;

	typedef struct packed {
		logic       write;
		logic [7:0] addr;	// Offset inside the region
		logic [7:0] data;
	} cpuBusT;

	// Active low
	typedef struct packed {
		logic start;
		logic coin;
		logic shot2;
		logic shot1;
		logic up;
		logic down;
		logic left;
		logic right;
	} playerT;

	typedef struct packed {
		logic [5:0] index;
		logic       blank;
	} palIdxT;

	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgbT;

	typedef struct packed {
		rgbT  rgb;
		logic blank;
	} videoT;

	typedef enum logic [2:0] {
		REG_CHAR,
		REG_FONT,
		REG_PAL,
		REG_INPUT,
		REG_CTRL,
		REG_NONE
	} regionT;

	typedef enum logic {
		BUS_IDLE,
		BUS_WAIT
	} busStateT;

endpackage
